// File: eth_frame_pkg.sv
package eth_frame_pkg;

  // metadata holds the destination mac in the upper 48 bits and the ethertype below it.
  localparam int meta_w = 64;

  localparam int hdr_len = 14; // destination, source and ethertype bytes.
  localparam int fcs_len = 4;  // crc-32 check bytes.

  // reflected form of the ieee 802.3 polynomial.
  localparam logic [31:0] crc_poly = 32'hEDB88320;

  // the same value seeds the register and inverts the final result.
  localparam logic [31:0] crc_init = 32'hFFFFFFFF;

endpackage : eth_frame_pkg

// File: eth_tx_crc.sv
`timescale 1ns/1ps

module eth_tx_crc (
  input  logic       clk,
  input  logic       rst,
  input  logic       crc_clear,
  input  logic       crc_en,
  input  logic [7:0] crc_dat,
  input  logic       fcs_shift,
  output logic [7:0] fcs_byte
);

  logic [31:0] crc;
  logic [31:0] crc_out;

  // one byte of the reflected crc-32, bit zero first.
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h000000, d};
    for (int b = 0; b < 8; b++) begin
      if (r[0]) r = (r >> 1) ^ eth_frame_pkg::crc_poly;
      else r = r >> 1;
    end
    return r;
  endfunction

  assign crc_out = crc ^ eth_frame_pkg::crc_init;

  always_ff @(posedge clk) begin
    if (rst || crc_clear) begin
      crc <= eth_frame_pkg::crc_init;
    end else if (crc_en) begin
      crc <= crc_byte(crc, crc_dat);
    end else if (fcs_shift) begin
      crc <= (crc_out >> 8) ^ eth_frame_pkg::crc_init; // the inverted value moves down a byte.
    end
  end

  assign fcs_byte = crc_out[7:0];

  a_en_shift: assert property (@(posedge clk) disable iff (rst)
    !(crc_en && fcs_shift));

endmodule : eth_tx_crc

// File: eth_tx_ctrl.sv
`timescale 1ns/1ps

module eth_tx_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rdy_mux,
  input  eth_vlg_pkg::stream_t strm_mux,
  input  logic [7:0]           hdr_byte,
  input  logic [7:0]           fcs_byte,
  output logic                 req_mux,
  output logic                 acc_mux,
  output logic                 done_mux,
  output logic                 hdr_load,
  output logic                 hdr_shift,
  output logic                 crc_clear,
  output logic                 crc_en,
  output logic [7:0]           crc_dat,
  output logic                 fcs_shift,
  output eth_vlg_pkg::stream_t tx
);

  localparam int cw = $clog2(eth_frame_pkg::hdr_len);
  localparam logic [cw-1:0] hdr_last = cw'(eth_frame_pkg::hdr_len - 1);
  localparam logic [cw-1:0] fcs_last = cw'(eth_frame_pkg::fcs_len - 1);

  typedef enum logic [2:0] {idle_s, hdr_s, wait_s, pay_s, fcs_s, done_s} state_t;

  state_t        state;
  logic [cw-1:0] cnt; // byte index inside the header or check phase.

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle_s;
      cnt   <= '0;
    end else begin
      case (state)
        idle_s: begin
          if (rdy_mux) begin
            state <= hdr_s;
            cnt   <= '0;
          end
        end
        hdr_s: begin
          if (cnt == hdr_last) begin
            state <= wait_s;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        wait_s: begin
          if (strm_mux.val) state <= strm_mux.eof ? fcs_s : pay_s; // one byte payloads skip ahead.
        end
        pay_s: begin
          if (strm_mux.val && strm_mux.eof) state <= fcs_s;
        end
        fcs_s: begin
          if (cnt == fcs_last) state <= done_s;
          else cnt <= cnt + 1'b1;
        end
        done_s: state <= idle_s;
        default: state <= idle_s;
      endcase
    end
  end

  always_comb begin
    req_mux   = 1'b0;
    acc_mux   = 1'b0;
    done_mux  = 1'b0;
    hdr_load  = 1'b0;
    hdr_shift = 1'b0;
    crc_clear = 1'b0;
    crc_en    = 1'b0;
    crc_dat   = 8'h00;
    fcs_shift = 1'b0;
    tx        = '0;
    case (state)
      idle_s: begin
        req_mux   = rdy_mux;
        hdr_load  = rdy_mux;
        crc_clear = rdy_mux;
      end
      hdr_s: begin
        hdr_shift = 1'b1;
        crc_en    = 1'b1;
        crc_dat   = hdr_byte;
        tx.dat    = hdr_byte;
        tx.val    = 1'b1;
        tx.sof    = (cnt == '0);
        acc_mux   = (cnt == hdr_last); // the source starts streaming after this.
      end
      wait_s, pay_s: begin
        crc_en  = strm_mux.val;
        crc_dat = strm_mux.dat;
        tx.dat  = strm_mux.dat;
        tx.val  = strm_mux.val;
      end
      fcs_s: begin
        fcs_shift = 1'b1;
        tx.dat    = fcs_byte;
        tx.val    = 1'b1;
        tx.eof    = (cnt == fcs_last);
      end
      done_s: done_mux = 1'b1;
      default: ;
    endcase
  end

  // the arbiter keeps the grant until the done pulse.
  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    (state != idle_s) |-> rdy_mux);

  // payload bytes outside the payload window would be lost.
  a_strm_window: assert property (@(posedge clk) disable iff (rst)
    strm_mux.val |-> (state == wait_s || state == pay_s));

endmodule : eth_tx_ctrl

// File: eth_tx_hdr.sv
`timescale 1ns/1ps

module eth_tx_hdr #(
  parameter logic [47:0] src_mac = 48'h02_00_00_00_00_01
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            hdr_load,
  input  logic                            hdr_shift,
  input  logic [eth_frame_pkg::meta_w-1:0] meta,
  output logic [7:0]                      hdr_byte
);

  localparam int hw = eth_frame_pkg::hdr_len * 8;

  logic [hw-1:0] sr;

  // destination, source and ethertype are each sent most significant byte first.
  always_ff @(posedge clk) begin
    if (hdr_load) begin
      sr <= {meta[eth_frame_pkg::meta_w-1:16], src_mac, meta[15:0]};
    end else if (hdr_shift) begin
      sr <= {sr[hw-9:0], 8'h00};
    end
  end

  assign hdr_byte = sr[hw-1:hw-8]; // front of the register.

  a_load_shift: assert property (@(posedge clk) disable iff (rst)
    !(hdr_load && hdr_shift));

endmodule : eth_tx_hdr

// File: eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top #(
  parameter int          n       = 3,
  parameter logic [47:0] src_mac = 48'h02_00_00_00_00_01
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [n-1:0]                            rdy,
  input  logic [n-1:0][eth_frame_pkg::meta_w-1:0] meta,
  input  eth_vlg_pkg::stream_t [n-1:0]            strm,
  output logic [n-1:0]                            req,
  output logic [n-1:0]                            acc,
  output logic [n-1:0]                            done,
  output eth_vlg_pkg::stream_t                    tx
);

  logic                             rdy_mux;
  logic [eth_frame_pkg::meta_w-1:0] meta_mux;
  eth_vlg_pkg::stream_t             strm_mux;
  logic                             req_mux;
  logic                             acc_mux;
  logic                             done_mux;
  logic                             hdr_load;
  logic                             hdr_shift;
  logic [7:0]                       hdr_byte;
  logic                             crc_clear;
  logic                             crc_en;
  logic [7:0]                       crc_dat;
  logic                             fcs_shift;
  logic [7:0]                       fcs_byte;

  eth_vlg_tx_mux #(
    .n (n),
    .w (eth_frame_pkg::meta_w)
  ) u_mux (
    .clk      (clk),
    .rst      (rst),
    .rdy      (rdy),
    .meta     (meta),
    .strm     (strm),
    .req      (req),
    .acc      (acc),
    .done     (done),
    .rdy_mux  (rdy_mux),
    .meta_mux (meta_mux),
    .strm_mux (strm_mux),
    .req_mux  (req_mux),
    .acc_mux  (acc_mux),
    .done_mux (done_mux)
  );

  eth_tx_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .rdy_mux   (rdy_mux),
    .strm_mux  (strm_mux),
    .hdr_byte  (hdr_byte),
    .fcs_byte  (fcs_byte),
    .req_mux   (req_mux),
    .acc_mux   (acc_mux),
    .done_mux  (done_mux),
    .hdr_load  (hdr_load),
    .hdr_shift (hdr_shift),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_dat   (crc_dat),
    .fcs_shift (fcs_shift),
    .tx        (tx)
  );

  eth_tx_hdr #(
    .src_mac (src_mac)
  ) u_hdr (
    .clk       (clk),
    .rst       (rst),
    .hdr_load  (hdr_load),
    .hdr_shift (hdr_shift),
    .meta      (meta_mux),
    .hdr_byte  (hdr_byte)
  );

  eth_tx_crc u_crc (
    .clk       (clk),
    .rst       (rst),
    .crc_clear (crc_clear),
    .crc_en    (crc_en),
    .crc_dat   (crc_dat),
    .fcs_shift (fcs_shift),
    .fcs_byte  (fcs_byte)
  );

endmodule : eth_tx_top

// File: eth_vlg_pkg.sv
package eth_vlg_pkg;

  // one byte of a frame as it moves between the sources, the arbiter and the framer.
  typedef struct packed {
    logic [7:0] dat; // data byte.
    logic       val; // byte is valid on this cycle.
    logic       sof; // first byte of a frame.
    logic       eof; // last byte of a frame.
  } stream_t;

endpackage : eth_vlg_pkg

// File: eth_vlg_tx_mux.sv
`timescale 1ns/1ps

module eth_vlg_tx_mux #(
  parameter int n = 3,
  parameter int w = 64
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [n-1:0]                   rdy,
  input  logic [n-1:0][w-1:0]            meta,
  input  eth_vlg_pkg::stream_t [n-1:0]   strm,
  output logic [n-1:0]                   req,
  output logic [n-1:0]                   acc,
  output logic [n-1:0]                   done,
  output logic                           rdy_mux,
  output logic [w-1:0]                   meta_mux,
  output eth_vlg_pkg::stream_t           strm_mux,
  input  logic                           req_mux,
  input  logic                           acc_mux,
  input  logic                           done_mux
);

  localparam int iw = (n > 1) ? $clog2(n) : 1;

  typedef enum logic {idle_s, active_s} state_t;

  state_t        state;
  logic [n-1:0]  cur_rdy; // ready set frozen for the whole frame.
  logic [n-1:0]  grant;
  logic [iw-1:0] ind;

  onehot #(
    .n   (n),
    .msb (1'b1)
  ) u_grant (
    .i (cur_rdy),
    .o (grant)
  );

  always_comb begin
    ind = '0;
    for (int k = 0; k < n; k++) begin
      if (grant[k]) ind = iw'(k);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      cur_rdy  <= '0;
      rdy_mux  <= 1'b0;
      strm_mux <= '0;
    end else begin
      case (state)
        idle_s: begin
          cur_rdy <= rdy; // sample every cycle until someone asks.
          if (rdy != '0) state <= active_s;
        end
        active_s: begin
          strm_mux <= strm[ind];
          if (done_mux) begin
            state   <= idle_s;
            cur_rdy <= '0;
            rdy_mux <= 1'b0;
          end else begin
            rdy_mux <= |grant;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == active_s) meta_mux <= meta[ind];
  end

  // controller pulses go back to the granted source only.
  always_ff @(posedge clk) begin
    if (rst) begin
      req  <= '0;
      acc  <= '0;
      done <= '0;
    end else begin
      req  <= grant & {n{req_mux}};
      acc  <= grant & {n{acc_mux}};
      done <= grant & {n{done_mux}};
    end
  end

  a_pulse_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(req) && $onehot0(acc) && $onehot0(done));

endmodule : eth_vlg_tx_mux

// File: onehot.sv
`timescale 1ns/1ps

module onehot #(
  parameter int n   = 3,
  parameter bit msb = 1'b1
) (
  input  logic [n-1:0] i,
  output logic [n-1:0] o
);

  // the scan order decides which set bit wins, the last one found is kept.
  always_comb begin
    int idx;
    o = '0;
    for (int k = 0; k < n; k++) begin
      idx = msb ? k : n - 1 - k;
      if (i[idx]) begin
        o      = '0;
        o[idx] = 1'b1;
      end
    end
  end

endmodule : onehot

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_eth_tx -f src.f -o sim_eth_tx
./obj_dir/sim_eth_tx 2>&1 | tee sim.log
if grep -q "Testbench failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: src.f
eth_vlg_pkg.sv
eth_frame_pkg.sv
onehot.sv
eth_vlg_tx_mux.sv
eth_tx_ctrl.sv
eth_tx_hdr.sv
eth_tx_crc.sv
eth_tx_top.sv
tb_eth_tx.sv

// File: tb_eth_tx.sv
`timescale 1ns/1ps

module tb_eth_tx;

  localparam int n_src = 3;
  localparam int n_frames = 54; // four directed frames, then fifty random ones.
  localparam int max_len = 40;
  localparam int timeout_cycles = 200 * n_frames + 100;
  localparam logic [47:0] mac = 48'h02_1A_2B_3C_4D_5E;

  logic                             clk = 1'b0;
  logic                             rst;
  logic [n_src-1:0]                 rdy;
  logic [n_src-1:0][63:0]           meta;
  eth_vlg_pkg::stream_t [n_src-1:0] strm;
  logic [n_src-1:0]                 req;
  logic [n_src-1:0]                 acc;
  logic [n_src-1:0]                 done;
  eth_vlg_pkg::stream_t             tx;

  int          seed = 32'he13e;
  int          cyc = 0;
  int          f_src[n_frames];
  int          f_len[n_frames];
  int          f_rel[n_frames];  // earliest cycle at which the frame may be offered.
  int          f_gap[n_frames];  // idle cycles between acc and the first payload byte.
  int          f_wait[n_frames]; // idle cycles after the previous done.
  logic [63:0] f_meta[n_frames];
  logic [7:0]  f_pay[n_frames][max_len];
  int          src_list[n_src][n_frames];
  int          src_cnt[n_src];
  int          src_ptr[n_src];
  int          pred_ptr[n_src];
  int          st[n_src]; // 0 idle, 1 offering, 2 streaming, 3 waiting for done.
  int          bidx[n_src];
  int          cnt_down[n_src];
  int          dir_src[4] = '{0, 1, 2, 0};
  logic [7:0]  got_q[$];
  logic [7:0]  exp_q[$];
  int          exp_frame_q[$];
  bit          busy;
  bit          in_frame;
  bit          eof_seen;
  int          phase;
  int          cur;
  int          frames_checked;

  eth_tx_top #(
    .n       (n_src),
    .src_mac (mac)
  ) UUT (
    .clk  (clk),
    .rst  (rst),
    .rdy  (rdy),
    .meta (meta),
    .strm (strm),
    .req  (req),
    .acc  (acc),
    .done (done),
    .tx   (tx)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic fail_msg(input string why);
    $display("%0t: %s", $time, why);
    abort_run();
  endtask

  // expected bytes of frame f: header, payload, then the inverted reflected crc-32.
  function automatic void build_expected(input int f);
    logic [31:0] c;
    logic [7:0]  b;
    logic        fb;
    int          body_len;
    exp_q.delete();
    for (int k = 0; k < 6; k++) exp_q.push_back(f_meta[f][63-8*k -: 8]);
    for (int k = 0; k < 6; k++) exp_q.push_back(mac[47-8*k -: 8]);
    exp_q.push_back(f_meta[f][15:8]);
    exp_q.push_back(f_meta[f][7:0]);
    for (int k = 0; k < f_len[f]; k++) exp_q.push_back(f_pay[f][k]);
    body_len = exp_q.size();
    c = 32'hFFFFFFFF;
    for (int k = 0; k < body_len; k++) begin
      b = exp_q[k];
      for (int j = 0; j < 8; j++) begin
        fb = c[0] ^ b[j];
        c  = {1'b0, c[31:1]};
        if (fb) c = c ^ 32'hEDB88320;
      end
    end
    c = ~c;
    for (int k = 0; k < 4; k++) exp_q.push_back(c[8*k +: 8]); // least significant byte first.
  endfunction

  task automatic build_frames();
    int s;
    for (int f = 0; f < n_frames; f++) begin
      s = int'($unsigned($random(seed)) % n_src);
      f_len[f] = 1 + int'($unsigned($random(seed)) % max_len);
      f_rel[f] = 450;
      case (f)
        0: begin s = 0; f_len[f] = 20; f_rel[f] = 30; end
        1: begin s = 0; f_len[f] = 1; f_rel[f] = 200; end
        2: begin s = 1; f_len[f] = 40; f_rel[f] = 200; end
        3: begin s = 2; f_len[f] = 12; f_rel[f] = 215; end // arrives while source 1 sends.
        default: ;
      endcase
      f_src[f]  = s;
      f_gap[f]  = int'($unsigned($random(seed)) % 4);
      f_wait[f] = int'($unsigned($random(seed)) % 6);
      f_meta[f] = {$random(seed), $random(seed)};
      for (int b = 0; b < max_len; b++) f_pay[f][b] = 8'($random(seed));
      src_list[s][src_cnt[s]] = f;
      src_cnt[s]++;
    end
  endtask

  // one cycle of the source model for source i.
  task automatic drive_source(input int i);
    int f;
    f = (src_ptr[i] < src_cnt[i]) ? src_list[i][src_ptr[i]] : 0;
    if (st[i] == 3) begin
      strm[i] = '0;
      if (done[i]) begin
        src_ptr[i]++;
        st[i] = 0;
        f = (src_ptr[i] < src_cnt[i]) ? src_list[i][src_ptr[i]] : 0;
        cnt_down[i] = f_wait[f];
      end
    end
    if (st[i] == 0) begin
      if (cnt_down[i] > 0) cnt_down[i]--;
      else if (src_ptr[i] < src_cnt[i] && cyc >= f_rel[f]) begin
        rdy[i]  = 1'b1;
        meta[i] = f_meta[f];
        st[i]   = 1;
      end
    end else if (st[i] == 1 && acc[i]) begin
      rdy[i]      = 1'b0;
      st[i]       = 2;
      bidx[i]     = 0;
      cnt_down[i] = f_gap[f];
    end
    if (st[i] == 2) begin
      strm[i] = '0;
      if (cnt_down[i] > 0) cnt_down[i]--;
      else begin
        strm[i].dat = f_pay[f][bidx[i]];
        strm[i].val = 1'b1;
        strm[i].sof = (bidx[i] == 0);
        strm[i].eof = (bidx[i] == f_len[f] - 1);
        bidx[i]++;
        if (bidx[i] == f_len[f]) st[i] = 3;
      end
    end
  endtask

  task automatic monitor_tx();
    int f;
    if (tx.val) begin
      if (tx.sof) begin
        if (in_frame) fail_msg("a new frame started before the previous one ended");
        in_frame = 1'b1;
        got_q.delete();
      end else if (!in_frame) fail_msg("a byte left the framer outside of a frame");
      got_q.push_back(tx.dat);
      if (tx.eof) begin
        if (exp_frame_q.size() == 0) fail_msg("a frame arrived with no predicted grant");
        f = exp_frame_q.pop_front();
        build_expected(f);
        check_val("frame length", 64'(got_q.size()), 64'(exp_q.size()));
        for (int k = 0; k < exp_q.size(); k++)
          check_val($sformatf("tx.dat byte %0d", k), 64'(got_q[k]), 64'(exp_q[k]));
        frames_checked++;
        in_frame = 1'b0;
        eof_seen = 1'b1;
      end
    end else if (tx.sof || tx.eof) fail_msg("tx carries a frame flag without valid");
  endtask

  // pulses must follow req, acc, done and reach only the predicted source.
  task automatic check_pulses();
    if (!busy) check_val("tx.val", 64'(tx.val), 64'(0));
    if (req != '0) begin
      if (!busy || phase != 0) fail_msg("req pulse without a new grant");
      check_val("req", 64'(req), 64'(3'b001 << cur));
      if (frames_checked < 4)
        check_val("req order", 64'(req), 64'(3'b001 << dir_src[frames_checked]));
      phase = 1;
    end
    if (acc != '0) begin
      if (phase != 1) fail_msg("acc pulse without a req before it");
      check_val("acc", 64'(acc), 64'(3'b001 << cur));
      phase = 2;
    end
    if (done != '0) begin
      if (phase != 2 || !eof_seen) fail_msg("done pulse before the frame was complete");
      check_val("done", 64'(done), 64'(3'b001 << cur));
      busy  = 1'b0;
      phase = 0;
    end
  endtask

  task automatic predict_grant();
    int w;
    w = 0;
    if (!busy && rdy != '0) begin
      for (int k = 0; k < n_src; k++) if (rdy[k]) w = k; // highest index wins.
      if (pred_ptr[w] >= src_cnt[w]) fail_msg("a source is ready with no frame left");
      exp_frame_q.push_back(src_list[w][pred_ptr[w]]);
      pred_ptr[w]++;
      cur      = w;
      busy     = 1'b1;
      phase    = 0;
      eof_seen = 1'b0;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      monitor_tx();
      check_pulses();
      predict_grant();
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("run timed out after %0d cycles, %0d of %0d frames checked",
               cyc, frames_checked, n_frames);
      abort_run();
    end
  end

  initial begin
    rst  = 1'b1;
    rdy  = '0;
    meta = '0;
    strm = '0;
    build_frames();
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    while (!(frames_checked == n_frames && !busy)) begin
      @(posedge clk);
      #1;
      for (int i = 0; i < n_src; i++) drive_source(i);
    end
    repeat (5) @(posedge clk); // stray pulses would still be caught here.
    $display("Testbench passed");
    $finish;
  end

endmodule : tb_eth_tx
